//--- rdreq_top.f
rdreq_pkg.sv
rdreq_apb_regs.sv
rdreq_burst_counter.sv
rdreq_rr_scanner.sv
rdreq_tag_tracker.sv
rdreq_top.sv
tb_rdreq.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rdreq \
   -f rdreq_top.f -o tb_rdreq > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_rdreq > sim.log 2>&1
cat sim.log

grep -q "^=== PASS ===$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- tb_rdreq.sv
// Self-checking testbench for the read-request issuer; run it as the simulation top with the RTL.

`timescale 1ns/1ps

module tb_rdreq;

   import rdreq_pkg::*;

   localparam int CLOCK_PERIOD    = 100;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 2000;
   localparam int READY_LOW       = 0;
   localparam int READY_HIGH      = 1;
   localparam int READY_RANDOM    = 2;

   // DUT inputs start at their idle values.
   logic       clock     = 1'b0;
   logic       reset     = 1'b1;
   logic       psel      = 1'b0;
   logic       penable   = 1'b0;
   logic       pwrite    = 1'b0;
   apb_addr_t  paddr     = '0;
   apb_data_t  pwdata    = '0;
   logic       rd_ready  = 1'b0;
   logic       cpl_valid = 1'b0;
   req_tag_t   cpl_tag   = '0;

   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       rd_valid;
   line_addr_t rd_addr;
   req_tag_t   rd_tag;

   // Accepted requests, in order of acceptance.
   line_addr_t acc_addr [$];
   req_tag_t   acc_tag [$];

   // Reference model of bases, free masks and requests seen per channel.
   line_addr_t             model_base [NUM_CH] = '{default: '0};
   logic [TAGS_PER_CH-1:0] model_used [NUM_CH] = '{default: '0};
   int                     issued [NUM_CH]     = '{default: 0};
   int                     lines [NUM_CH]      = '{default: 0};

   int          scored         = 0;
   ch_idx_t     last_ch        = '0;
   logic        rot_check      = 1'b0;
   int          ready_mode     = READY_LOW;
   logic [31:0] rng_state      = 32'd38;
   int          checks         = 0;
   int          errors         = 0;
   int          tests_run      = 0;
   int          tests_failed   = 0;
   int          test_err_start = 0;

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   rdreq_top uut
   (
      .clock       (clock),
      .reset       (reset),
      .i_psel      (psel),
      .i_penable   (penable),
      .i_pwrite    (pwrite),
      .i_paddr     (paddr),
      .i_pwdata    (pwdata),
      .o_prdata    (prdata),
      .o_pready    (pready),
      .o_pslverr   (pslverr),
      .o_rd_valid  (rd_valid),
      .o_rd_addr   (rd_addr),
      .o_rd_tag    (rd_tag),
      .i_rd_ready  (rd_ready),
      .i_cpl_valid (cpl_valid),
      .i_cpl_tag   (cpl_tag)
   );

   // Request monitor.
   // Valid and ready are both stable at the falling edge before the accepting edge.
   always @(negedge clock)
   begin
      if (!reset && rd_valid && rd_ready)
      begin
         acc_addr.push_back(rd_addr);
         acc_tag.push_back(rd_tag);
      end
   end

   // Watchdog sized from the test budget.
   initial
   begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles",
               NUM_TESTS * CYCLES_PER_TEST);
      $display("=== FAIL ===");
      $finish;
   end

   // Xorshift generator for back-pressure and completion order.
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Expected {address, tag} for request n of a burst.
   // Line n sits n lines above the base; the lowest free tag goes out.
   function automatic logic [39:0] ref_request(input ch_idx_t ch, input int n);
      int t;
      t = 0;
      while ((t < TAGS_PER_CH - 1) && model_used[ch][tag_low_t'(t)])
         t++;
      return {model_base[ch] + line_addr_t'(n), 2'b00, ch, 1'b0, tag_low_t'(t)};
   endfunction

   task automatic check(input logic [39:0] got, input logic [39:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   function automatic apb_addr_t reg_addr(input ch_idx_t ch, input apb_addr_t off);
      return {2'b00, ch, 4'h0} | off;
   endfunction

   // One APB transfer; response sampled mid access phase.
   task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err);
      @(posedge clock);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clock);
      penable <= 1'b1;
      @(negedge clock);
      rdata = prdata;
      err   = pslverr;
      // Every access completes in its access phase.
      check(40'(pready), 40'd1, "PREADY in access phase");
      @(posedge clock);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      apb_data_t unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   // Compare every new accepted request with the model, then mark its tag used.
   task automatic score_requests();
      ch_idx_t     ch;
      ch_idx_t     next_ch;
      logic [39:0] exp;
      while (scored < acc_addr.size())
      begin
         ch  = acc_tag[scored][5:4];
         exp = ref_request(ch, issued[ch]);
         check(40'(issued[ch] < lines[ch]), 40'd1, "request inside burst");
         check(40'(acc_addr[scored]), 40'(exp[39:8]), "request address");
         check(40'(acc_tag[scored]), 40'(exp[7:0]), "request tag");
         // Rotation wraps from channel 3 back to channel 0.
         next_ch = last_ch + ch_idx_t'(1);
         if (rot_check)
            check(40'(ch), 40'(next_ch), "channel rotation");
         last_ch = ch;
         model_used[ch][acc_tag[scored][2:0]] = 1'b1;
         issued[ch]++;
         scored++;
      end
   endtask

   // One cycle of waiting; ready follows the current mode.
   task automatic tick();
      logic [31:0] r;
      @(posedge clock);
      case (ready_mode)
         READY_HIGH:
         begin
            rd_ready <= 1'b1;
         end
         READY_RANDOM:
         begin
            r = next_random();
            rd_ready <= r[3];
         end
         default:
         begin
            rd_ready <= 1'b0;
         end
      endcase
      score_requests();
   endtask

   task automatic set_ready(input int mode);
      ready_mode = mode;
      tick();
   endtask

   task automatic wait_lines(input ch_idx_t ch, input int n);
      while (issued[ch] < n)
         tick();
   endtask

   task automatic wait_valid();
      do
         @(negedge clock);
      while (!rd_valid);
   endtask

   task automatic load_channel(input ch_idx_t ch, input line_addr_t base, input int count);
      logic err;
      model_base[ch] = base;
      issued[ch]     = 0;
      lines[ch]      = count;
      apb_write(reg_addr(ch, REG_BASE), apb_data_t'(base), err);
      check(40'(err), 40'd0, "BASE write error");
      apb_write(reg_addr(ch, REG_COUNT), apb_data_t'(count), err);
      check(40'(err), 40'd0, "COUNT write error");
   endtask

   // Completion for one tag; the tracker frees it on the second edge.
   task automatic return_tag(input ch_idx_t ch, input tag_low_t t);
      @(posedge clock);
      cpl_valid <= 1'b1;
      cpl_tag   <= {2'b00, ch, 1'b0, t};
      @(posedge clock);
      cpl_valid <= 1'b0;
      model_used[ch][t] = 1'b0;
   endtask

   task automatic release_all();
      score_requests();
      for (int c = 0; c < NUM_CH; c++)
         for (int t = 0; t < TAGS_PER_CH; t++)
            if (model_used[ch_idx_t'(c)][tag_low_t'(t)])
               return_tag(ch_idx_t'(c), tag_low_t'(t));
   endtask

   task automatic begin_test();
      test_err_start = errors;
   endtask

   task automatic end_test(input string name);
      score_requests();
      for (int c = 0; c < NUM_CH; c++)
         check(40'(issued[ch_idx_t'(c)]), 40'(lines[ch_idx_t'(c)]), "lines requested");
      tests_run++;
      if (errors == test_err_start)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - test_err_start);
      end
   endtask

   initial
   begin : stimulus
      logic      err;
      apb_data_t data;
      tag_low_t  order [TAGS_PER_CH];
      tag_low_t  tmp;
      int        j;
      repeat (3) @(posedge clock);
      reset <= 1'b0;

      // Reset state gives an idle output and clear status.
      begin_test();
      repeat (20)
      begin
         @(negedge clock);
         check(40'(rd_valid), 40'd0, "valid after reset");
      end
      for (int c = 0; c < NUM_CH; c++)
      begin
         apb_read(reg_addr(ch_idx_t'(c), REG_STATUS), data, err);
         check(40'(data), 40'd0, "STATUS after reset");
         check(40'(err), 40'd0, "STATUS read error");
      end
      end_test("reset state");

      // Register access and error responses.
      begin_test();
      set_ready(READY_LOW);
      apb_write(reg_addr(2'd0, REG_BASE), 32'hCAFE_0040, err);
      apb_read(reg_addr(2'd0, REG_BASE), data, err);
      check(40'(data), 40'hCAFE_0040, "BASE readback");
      apb_write(reg_addr(2'd0, REG_STATUS), 32'h1, err);
      check(40'(err), 40'd1, "STATUS write error");
      apb_read(reg_addr(2'd1, 8'h0C), data, err);
      check(40'(err), 40'd1, "offset 0xC error");
      // Burst stalls on its first request, so the channel stays busy.
      load_channel(2'd3, 32'h0000_0100, 4);
      wait_valid();
      apb_write(reg_addr(2'd3, REG_COUNT), 32'd9, err);
      check(40'(err), 40'd1, "COUNT write during burst");
      apb_read(reg_addr(2'd3, REG_STATUS), data, err);
      check(40'(data[12:0]), 40'd3, "remaining after refused COUNT");
      set_ready(READY_HIGH);
      wait_lines(2'd3, 4);
      release_all();
      end_test("register access");

      // Single burst on channel 1.
      begin_test();
      load_channel(2'd1, 32'h0012_3450, 5);
      wait_lines(2'd1, 5);
      apb_read(reg_addr(2'd1, REG_STATUS), data, err);
      check(40'(data[12:0]), 40'd0, "remaining after burst");
      check(40'(data[19:16]), 40'd5, "tags in use after burst");
      release_all();
      end_test("single burst");

      // Round robin under random back-pressure.
      // Channel 0 holds the port while the others load, so all start together.
      begin_test();
      set_ready(READY_LOW);
      load_channel(2'd0, 32'h0000_2000, 4);
      wait_valid();
      load_channel(2'd1, 32'h0000_3000, 4);
      load_channel(2'd2, 32'h0000_4000, 4);
      load_channel(2'd3, 32'hFFFF_FFFE, 4);
      last_ch   = 2'd3;
      rot_check = 1'b1;
      set_ready(READY_RANDOM);
      for (int c = 0; c < NUM_CH; c++)
         wait_lines(ch_idx_t'(c), 4);
      rot_check = 1'b0;
      set_ready(READY_HIGH);
      release_all();
      end_test("round robin");

      // Tag exhaustion on channel 2.
      begin_test();
      load_channel(2'd2, 32'h0000_6000, 12);
      wait_lines(2'd2, TAGS_PER_CH);
      repeat (50) tick();
      check(40'(issued[2]), 40'(TAGS_PER_CH), "requests without completions");
      apb_read(reg_addr(2'd2, REG_STATUS), data, err);
      check(40'(data[19:16]), 40'd8, "tags in use when exhausted");
      check(40'(data[12:0]), 40'd4, "remaining when exhausted");
      // Park the scanner on channel 0 so the frees all land first.
      set_ready(READY_LOW);
      load_channel(2'd0, 32'h0000_7000, 1);
      wait_valid();
      for (int i = 0; i < TAGS_PER_CH; i++)
         order[i] = tag_low_t'(i);
      for (int i = TAGS_PER_CH - 1; i > 0; i--)
      begin
         j        = int'(next_random() % 32'(i + 1));
         tmp      = order[i];
         order[i] = order[tag_low_t'(j)];
         order[tag_low_t'(j)] = tmp;
      end
      // Six tags come back; the four lowest of them get reused.
      for (int i = 0; i < 6; i++)
         return_tag(2'd2, order[i]);
      set_ready(READY_HIGH);
      wait_lines(2'd0, 1);
      wait_lines(2'd2, 12);
      release_all();
      end_test("tag exhaustion");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- rdreq_top.sv
// Top level of the read-request issuer; wires registers, counters, scanner and tag tracker.

`timescale 1ns/1ps

module rdreq_top
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  rdreq_pkg::apb_addr_t  i_paddr,
   input  rdreq_pkg::apb_data_t  i_pwdata,
   output rdreq_pkg::apb_data_t  o_prdata,
   output logic                  o_pready,
   output logic                  o_pslverr,
   output logic                  o_rd_valid,
   output rdreq_pkg::line_addr_t o_rd_addr,
   output rdreq_pkg::req_tag_t   o_rd_tag,
   input  logic                  i_rd_ready,
   input  logic                  i_cpl_valid,
   input  rdreq_pkg::req_tag_t   i_cpl_tag
);

   import rdreq_pkg::*;

   // Register block to counters.
   logic [NUM_CH-1:0]  load;
   line_addr_t         load_addr [NUM_CH];
   line_count_t        load_count [NUM_CH];

   // Counters to scanner and register block.
   logic [NUM_CH-1:0]  pending;
   line_addr_t         addr [NUM_CH];
   line_count_t        remaining [NUM_CH];

   // Scanner and tracker.
   logic [NUM_CH-1:0]  take;
   logic [NUM_CH-1:0]  tag_avail;
   tag_low_t           free_tag [NUM_CH];
   logic [TAG_LOW_W:0] tags_used [NUM_CH];
   logic               alloc;
   ch_idx_t            alloc_ch;
   tag_low_t           alloc_tag;

   rdreq_apb_regs u_regs
   (
      .clock        (clock),
      .reset        (reset),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr),
      .i_pending    (pending),
      .i_remaining  (remaining),
      .i_tags_used  (tags_used),
      .o_load       (load),
      .o_load_addr  (load_addr),
      .o_load_count (load_count)
   );

   // One burst counter per channel.
   for (genvar c = 0; c < NUM_CH; c++)
   begin : g_ch
      rdreq_burst_counter u_cnt
      (
         .clock        (clock),
         .reset        (reset),
         .i_load       (load[c]),
         .i_load_addr  (load_addr[c]),
         .i_load_count (load_count[c]),
         .i_take       (take[c]),
         .o_pending    (pending[c]),
         .o_addr       (addr[c]),
         .o_remaining  (remaining[c])
      );
   end

   rdreq_rr_scanner u_scan
   (
      .clock       (clock),
      .reset       (reset),
      .i_pending   (pending),
      .i_addr      (addr),
      .i_tag_avail (tag_avail),
      .i_free_tag  (free_tag),
      .o_take      (take),
      .o_alloc     (alloc),
      .o_alloc_ch  (alloc_ch),
      .o_alloc_tag (alloc_tag),
      .o_rd_valid  (o_rd_valid),
      .o_rd_addr   (o_rd_addr),
      .o_rd_tag    (o_rd_tag),
      .i_rd_ready  (i_rd_ready)
   );

   rdreq_tag_tracker u_tags
   (
      .clock       (clock),
      .reset       (reset),
      .i_alloc     (alloc),
      .i_alloc_ch  (alloc_ch),
      .i_alloc_tag (alloc_tag),
      .i_cpl_valid (i_cpl_valid),
      .i_cpl_tag   (i_cpl_tag),
      .o_tag_avail (tag_avail),
      .o_free_tag  (free_tag),
      .o_tags_used (tags_used)
   );

endmodule

//--- rdreq_tag_tracker.sv
// Tag tracker; keeps per-channel in-use masks, offers the lowest free tag and frees tags on completion.

`timescale 1ns/1ps

module rdreq_tag_tracker
(
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            i_alloc,
   input  rdreq_pkg::ch_idx_t              i_alloc_ch,
   input  rdreq_pkg::tag_low_t             i_alloc_tag,
   input  logic                            i_cpl_valid,
   input  rdreq_pkg::req_tag_t             i_cpl_tag,
   output logic [rdreq_pkg::NUM_CH-1:0]    o_tag_avail,
   output rdreq_pkg::tag_low_t             o_free_tag [rdreq_pkg::NUM_CH],
   output logic [rdreq_pkg::TAG_LOW_W:0]   o_tags_used [rdreq_pkg::NUM_CH]
);

   import rdreq_pkg::*;

   // One bit per tag, set while a request is outstanding.
   logic [TAGS_PER_CH-1:0] used_q [NUM_CH];

   ch_idx_t  cpl_ch;
   tag_low_t cpl_low;

   // Completion tag fields.
   assign cpl_ch  = i_cpl_tag[5:4];
   assign cpl_low = i_cpl_tag[2:0];

   // Set on allocate, clear on completion.
   // Both apply in the same cycle since they never hit the same bit.
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int c = 0; c < NUM_CH; c++)
            used_q[c] <= '0;
      end
      else
      begin
         for (int c = 0; c < NUM_CH; c++)
         begin
            if (i_alloc && (i_alloc_ch == ch_idx_t'(c)))
               used_q[c][i_alloc_tag] <= 1'b1;
            if (i_cpl_valid && (cpl_ch == ch_idx_t'(c)))
               used_q[c][cpl_low] <= 1'b0;
         end
      end
   end

   // Lowest clear bit per channel.
   // Scanning from the top lets the lowest free tag win.
   always_comb
   begin
      for (int c = 0; c < NUM_CH; c++)
      begin
         o_tag_avail[c] = ~&used_q[c];
         o_free_tag[c]  = '0;
         for (int t = TAGS_PER_CH - 1; t >= 0; t--)
         begin
            if (!used_q[c][t])
               o_free_tag[c] = tag_low_t'(t);
         end
         // Outstanding count for STATUS.
         o_tags_used[c] = (TAG_LOW_W + 1)'($countones(used_q[c]));
      end
   end

   // Completions only return tags that were issued.
   a_cpl_used : assert property (@(posedge clock) disable iff (reset)
      i_cpl_valid |-> used_q[cpl_ch][cpl_low]);

   // The scanner only allocates a tag that is free.
   a_alloc_free : assert property (@(posedge clock) disable iff (reset)
      i_alloc |-> !used_q[i_alloc_ch][i_alloc_tag]);

endmodule

//--- rdreq_rr_scanner.sv
// Round-robin scanner; visits channels in turn and issues one single-line read request per grant.

`timescale 1ns/1ps

module rdreq_rr_scanner
(
   input  logic                            clock,
   input  logic                            reset,
   input  logic [rdreq_pkg::NUM_CH-1:0]    i_pending,
   input  rdreq_pkg::line_addr_t           i_addr [rdreq_pkg::NUM_CH],
   input  logic [rdreq_pkg::NUM_CH-1:0]    i_tag_avail,
   input  rdreq_pkg::tag_low_t             i_free_tag [rdreq_pkg::NUM_CH],
   output logic [rdreq_pkg::NUM_CH-1:0]    o_take,
   output logic                            o_alloc,
   output rdreq_pkg::ch_idx_t              o_alloc_ch,
   output rdreq_pkg::tag_low_t             o_alloc_tag,
   output logic                            o_rd_valid,
   output rdreq_pkg::line_addr_t           o_rd_addr,
   output rdreq_pkg::req_tag_t             o_rd_tag,
   input  logic                            i_rd_ready
);

   import rdreq_pkg::*;

   // Phase and channel under scan.
   scan_phase_e phase_q;
   ch_idx_t     ch_q;

   // Request payload captured in CHECK.
   line_addr_t  addr_q;
   tag_low_t    tag_q;

   logic        grant;

   // A channel is served only with lines left and a free tag.
   assign grant = i_pending[ch_q] & i_tag_avail[ch_q];

   // Phase machine.
   // CHECK without a grant steps straight to the next channel.
   // PRESENT waits for ready, then steps to the next channel.
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         phase_q <= CHECK;
         ch_q    <= '0;
      end
      else
      begin
         case (phase_q)
            CHECK:
            begin
               if (grant)
                  phase_q <= ALLOC;
               else
                  ch_q <= ch_q + ch_idx_t'(1);
            end
            ALLOC:
            begin
               phase_q <= SETTLE;
            end
            SETTLE:
            begin
               phase_q <= PRESENT;
            end
            PRESENT:
            begin
               if (i_rd_ready)
               begin
                  phase_q <= CHECK;
                  ch_q    <= ch_q + ch_idx_t'(1);
               end
            end
            default:
            begin
               phase_q <= CHECK;
            end
         endcase
      end
   end

   // Capture address and lowest free tag on a grant.
   // They hold until the next grant, so the request stays stable.
   always_ff @(posedge clock)
   begin
      if ((phase_q == CHECK) && grant)
      begin
         addr_q <= i_addr[ch_q];
         tag_q  <= i_free_tag[ch_q];
      end
   end

   // ALLOC steps the counter and marks the tag in use.
   always_comb
   begin
      o_take = '0;
      if (phase_q == ALLOC)
         o_take[ch_q] = 1'b1;
   end

   assign o_alloc     = (phase_q == ALLOC);
   assign o_alloc_ch  = ch_q;
   assign o_alloc_tag = tag_q;

   // Request output.
   // Channel sits in tag bits 5:4, low tag in bits 2:0.
   assign o_rd_valid = (phase_q == PRESENT);
   assign o_rd_addr  = addr_q;
   assign o_rd_tag   = {2'b00, ch_q, 1'b0, tag_q};

   // A stalled request keeps its valid, address and tag.
   a_req_stable : assert property (@(posedge clock) disable iff (reset)
      o_rd_valid && !i_rd_ready |=> o_rd_valid && $stable(o_rd_addr) && $stable(o_rd_tag));

endmodule

//--- rdreq_burst_counter.sv
// Per-channel burst counter; tracks the next line address and the lines still to request.

`timescale 1ns/1ps

module rdreq_burst_counter
(
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   i_load,
   input  rdreq_pkg::line_addr_t  i_load_addr,
   input  rdreq_pkg::line_count_t i_load_count,
   input  logic                   i_take,
   output logic                   o_pending,
   output rdreq_pkg::line_addr_t  o_addr,
   output rdreq_pkg::line_count_t o_remaining
);

   import rdreq_pkg::*;

   // Address and count.
   // A load restarts the burst at the programmed base.
   // Each take moves to the next 64-byte line.
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         o_addr      <= '0;
         o_remaining <= '0;
      end
      else if (i_load)
      begin
         o_addr      <= i_load_addr;
         o_remaining <= i_load_count;
      end
      else if (i_take)
      begin
         o_addr      <= o_addr + line_addr_t'(1);
         o_remaining <= o_remaining - line_count_t'(1);
      end
   end

   // Pending trails the count by one cycle.
   // The scanner's SETTLE phase covers that lag.
   always_ff @(posedge clock)
   begin
      if (reset)
         o_pending <= 1'b0;
      else
         o_pending <= (o_remaining != '0);
   end

   // The scanner only takes from a channel with lines left.
   a_take_nonzero : assert property (@(posedge clock) disable iff (reset)
      i_take |-> (o_remaining != '0));

endmodule

//--- rdreq_apb_regs.sv
// APB configuration slave; holds per-channel base registers, starts bursts and reports status.

`timescale 1ns/1ps

module rdreq_apb_regs
(
   input  logic                              clock,
   input  logic                              reset,
   input  logic                              i_psel,
   input  logic                              i_penable,
   input  logic                              i_pwrite,
   input  rdreq_pkg::apb_addr_t              i_paddr,
   input  rdreq_pkg::apb_data_t              i_pwdata,
   output rdreq_pkg::apb_data_t              o_prdata,
   output logic                              o_pready,
   output logic                              o_pslverr,
   input  logic [rdreq_pkg::NUM_CH-1:0]      i_pending,
   input  rdreq_pkg::line_count_t            i_remaining [rdreq_pkg::NUM_CH],
   input  logic [rdreq_pkg::TAG_LOW_W:0]     i_tags_used [rdreq_pkg::NUM_CH],
   output logic [rdreq_pkg::NUM_CH-1:0]      o_load,
   output rdreq_pkg::line_addr_t             o_load_addr [rdreq_pkg::NUM_CH],
   output rdreq_pkg::line_count_t            o_load_count [rdreq_pkg::NUM_CH]
);

   import rdreq_pkg::*;

   // Programmed base line address per channel.
   line_addr_t base_q [NUM_CH];

   ch_idx_t    sel_ch;
   logic [1:0] sel_off;
   logic       access;
   logic       count_wr;

   // Decode of the current access.
   assign sel_ch   = i_paddr[5:4];
   assign sel_off  = i_paddr[3:2];
   assign access   = i_psel & i_penable;
   assign count_wr = access & i_pwrite & (sel_off == REG_COUNT[3:2]);

   // No wait states.
   assign o_pready = 1'b1;

   // Errors: reserved offset, STATUS write, or COUNT write on a busy channel.
   assign o_pslverr = access & ((sel_off == 2'd3) |
                                (i_pwrite & (sel_off == REG_STATUS[3:2])) |
                                (count_wr & i_pending[sel_ch]));

   // Base registers are written at the end of the access phase.
   always_ff @(posedge clock)
   begin
      if (access && i_pwrite && (sel_off == REG_BASE[3:2]))
         base_q[sel_ch] <= line_addr_t'(i_pwdata);
   end

   // Load strobe per channel.
   // A busy channel refuses the load, the counter then keeps its state.
   always_comb
   begin
      for (int c = 0; c < NUM_CH; c++)
      begin
         o_load[c]       = count_wr & (sel_ch == ch_idx_t'(c)) & ~i_pending[c];
         o_load_addr[c]  = base_q[c];
         o_load_count[c] = line_count_t'(i_pwdata);
      end
   end

   // Read data mux.
   // STATUS packs tags in use above the remaining count.
   always_comb
   begin
      o_prdata = '0;
      case (sel_off)
         REG_BASE[3:2]:   o_prdata = apb_data_t'(base_q[sel_ch]);
         REG_COUNT[3:2]:  o_prdata = apb_data_t'(i_remaining[sel_ch]);
         REG_STATUS[3:2]: o_prdata = {12'd0, i_tags_used[sel_ch], 3'd0, i_remaining[sel_ch]};
         default:         o_prdata = '0;
      endcase
   end

   // An accepted nonzero load lands on an idle channel.
   // The counter then reports pending two edges later.
   for (genvar c = 0; c < NUM_CH; c++)
   begin : g_chk
      a_load_idle : assert property (@(posedge clock) disable iff (reset)
         o_load[c] && (o_load_count[c] != '0) |-> !i_pending[c] ##2 i_pending[c]);
   end

endmodule

//--- rdreq_pkg.sv
// Shared widths, register map, types and scanner phases for the DMA read-request issuer.

package rdreq_pkg;

   // Channel and tag geometry.
   // Four channels, each owning eight tags.
   localparam int NUM_CH      = 4;
   localparam int CH_W        = 2;
   localparam int TAGS_PER_CH = 8;
   localparam int TAG_LOW_W   = 3;

   // Line address in 64-byte units.
   // Byte address is this value shifted left by 6.
   typedef logic [31:0] line_addr_t;

   // Lines still to be requested on one channel.
   typedef logic [12:0] line_count_t;

   // Channel index.
   typedef logic [CH_W-1:0] ch_idx_t;

   // Tag within one channel.
   typedef logic [TAG_LOW_W-1:0] tag_low_t;

   // Full request tag.
   // Layout is {2'b0, channel, 1'b0, low tag}.
   typedef logic [7:0] req_tag_t;

   // APB address and data.
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Register offsets in the 16-byte window of each channel.
   // Channel is selected by address bits 5:4.
   localparam apb_addr_t REG_BASE   = 8'h00;
   localparam apb_addr_t REG_COUNT  = 8'h04;
   localparam apb_addr_t REG_STATUS = 8'h08;

   // Scanner phases.
   // CHECK looks at one channel, ALLOC takes a line and a tag.
   // SETTLE lets counter and tracker flags catch up.
   // PRESENT holds the request until it is accepted.
   typedef enum logic [1:0]
   {
      CHECK   = 2'd0,
      ALLOC   = 2'd1,
      SETTLE  = 2'd2,
      PRESENT = 2'd3
   } scan_phase_e;

endpackage
